// ==== diag_select.sv ====
`timescale 1ns/1ps

// Picks max, median and min of the three anti-diagonal sets of M
module diag_select
  import pixel_pkg::*;
  import pipe_pkg::*;
(
  input  logic    ref_clk,
  input  logic    rst_n,
  input  logic    i_adv,
  input  window_t i_matrix,
  output pixel_t  o_dmax,
  output pixel_t  o_dmed,
  output pixel_t  o_dmin
);

  pixel_t [DIAG_MAX_LEN-1:0] max_set;
  pixel_t [DIAG_MAX_LEN-1:0] max_sorted;
  pixel_t [DIAG_MED_LEN-1:0] med_set;
  pixel_t [DIAG_MED_LEN-1:0] med_sorted;
  pixel_t [DIAG_MAX_LEN-1:0] min_set;
  pixel_t [DIAG_MAX_LEN-1:0] min_sorted;

  // Gather the diagonal entries, i_matrix[k][j] is row rank k, column rank j
  for (genvar i = 0; i < DIAG_MAX_LEN; i++) begin : g_side_sets
    assign max_set[i] = i_matrix[DMAX_K[i]][DMAX_J[i]];
    assign min_set[i] = i_matrix[DMIN_K[i]][DMIN_J[i]];
  end

  for (genvar i = 0; i < DIAG_MED_LEN; i++) begin : g_med_set
    assign med_set[i] = i_matrix[DMED_K[i]][DMED_J[i]];
  end

  sort_net #(
    .N (DIAG_MAX_LEN)
  ) max_sort_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_vals   (max_set),
    .o_sorted (max_sorted)
  );

  sort_net #(
    .N (DIAG_MED_LEN)
  ) med_sort_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_vals   (med_set),
    .o_sorted (med_sorted)
  );

  sort_net #(
    .N (DIAG_MAX_LEN)
  ) min_sort_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_vals   (min_set),
    .o_sorted (min_sorted)
  );

  // First, middle and last sorter lanes
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      o_dmax <= '0;
      o_dmed <= '0;
      o_dmin <= '0;
    end else if (i_adv) begin
      o_dmax <= max_sorted[0];
      o_dmed <= med_sorted[DIAG_MED_LEN/2];
      o_dmin <= min_sorted[DIAG_MAX_LEN-1];
    end
  end

endmodule

// ==== median_5x5.f ====
+incdir+.
pixel_pkg.sv
pipe_pkg.sv
sort_net.sv
rank_stage.sv
diag_select.sv
triple_sort.sv
pipe_ctrl.sv
median_5x5.sv
tb_median_5x5.sv

// ==== median_5x5.sv ====
`timescale 1ns/1ps

// 5x5 rank filter, four register stages with valid/ready on both sides
module median_5x5
  import pixel_pkg::*;
(
  input  logic    ref_clk,
  input  logic    rst_n,
  input  logic    i_valid,
  output logic    o_ready,
  input  window_t i_window,
  output logic    o_valid,
  input  logic    i_ready,
  output pixel_t  o_max,
  output pixel_t  o_med,
  output pixel_t  o_min
);

  logic    adv;
  window_t row_sorted;
  window_t rank_groups;
  window_t rank_matrix;
  pixel_t  dmax;
  pixel_t  dmed;
  pixel_t  dmin;

  pipe_ctrl pipe_ctrl_i (
    .ref_clk (ref_clk),
    .rst_n   (rst_n),
    .i_valid (i_valid),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .o_adv   (adv),
    .o_valid (o_valid)
  );

  // Stage 1, sort each image row
  rank_stage row_rank_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_adv    (adv),
    .i_groups (i_window),
    .o_sorted (row_sorted)
  );

  // Group the k-th ranked pixel of every row together
  for (genvar k = 0; k < WIN_SIZE; k++) begin : g_rank
    for (genvar r = 0; r < WIN_SIZE; r++) begin : g_row
      assign rank_groups[k][r] = row_sorted[r][k];
    end
  end

  // Stage 2, sort each rank across the rows, giving M[k][j]
  rank_stage col_rank_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_adv    (adv),
    .i_groups (rank_groups),
    .o_sorted (rank_matrix)
  );

  // Stage 3
  diag_select diag_select_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_adv    (adv),
    .i_matrix (rank_matrix),
    .o_dmax   (dmax),
    .o_dmed   (dmed),
    .o_dmin   (dmin)
  );

  // Stage 4
  triple_sort triple_sort_i (
    .ref_clk (ref_clk),
    .rst_n   (rst_n),
    .i_adv   (adv),
    .i_dmax  (dmax),
    .i_dmed  (dmed),
    .i_dmin  (dmin),
    .o_max   (o_max),
    .o_med   (o_med),
    .o_min   (o_min)
  );

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ps

// Valid tracking and global stall for the filter pipeline
module pipe_ctrl
  import pipe_pkg::*;
(
  input  logic ref_clk,
  input  logic rst_n,
  input  logic i_valid,
  input  logic i_ready,
  output logic o_ready,
  output logic o_adv,
  output logic o_valid
);

  // Bit n is set when stage n+1 holds a real window
  logic [PIPE_DEPTH-1:0] vld_q;

  assign o_valid = vld_q[PIPE_DEPTH-1];

  // Whole pipe moves unless a result waits for the consumer
  assign o_adv   = !o_valid || i_ready;
  assign o_ready = o_adv;

  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (o_adv) begin
      vld_q <= {vld_q[PIPE_DEPTH-2:0], i_valid};
    end
  end

  // A result under back-pressure is held until taken
  a_hold_valid: assert property (
    @(posedge ref_clk) disable iff (!rst_n)
    (o_valid && !i_ready) |=> $stable(o_valid)
  );

  // Input valid enters stage 1 whenever the output is empty
  a_adv_when_empty: assert property (
    @(posedge ref_clk) disable iff (!rst_n)
    !o_valid |=> (vld_q[0] == $past(i_valid))
  );

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

  // Register stages from input to result
  localparam int PIPE_DEPTH = 4;

  // Sizes of the three anti-diagonal sets
  localparam int DIAG_MAX_LEN = 4;
  localparam int DIAG_MED_LEN = 5;

  // Entries of M[k][j] for the max set, on the diagonal k + j = 5
  localparam int DMAX_K [DIAG_MAX_LEN] = '{1, 2, 3, 4};
  localparam int DMAX_J [DIAG_MAX_LEN] = '{4, 3, 2, 1};

  // Median set, the main anti-diagonal k + j = 4
  localparam int DMED_K [DIAG_MED_LEN] = '{0, 1, 2, 3, 4};
  localparam int DMED_J [DIAG_MED_LEN] = '{4, 3, 2, 1, 0};

  // Min set, on the diagonal k + j = 3
  localparam int DMIN_K [DIAG_MAX_LEN] = '{0, 1, 2, 3};
  localparam int DMIN_J [DIAG_MAX_LEN] = '{3, 2, 1, 0};

endpackage

// ==== pixel_pkg.sv ====
package pixel_pkg;

  // Pixel format
  localparam int PIXEL_W = 8;

  // Window edge length, the filter works on WIN_SIZE x WIN_SIZE pixels
  localparam int WIN_SIZE = 5;

  typedef logic [PIXEL_W-1:0] pixel_t;

  // One row of the window, element 0 is the leftmost pixel
  typedef pixel_t [WIN_SIZE-1:0] row_t;

  // Whole window, element 0 is the top row
  typedef row_t [WIN_SIZE-1:0] window_t;

endpackage

// ==== rank_stage.sv ====
`timescale 1ns/1ps

// Sorts five groups of five pixels and registers the ranked groups
module rank_stage
  import pixel_pkg::*;
(
  input  logic    ref_clk,
  input  logic    rst_n,
  input  logic    i_adv,
  input  window_t i_groups,
  output window_t o_sorted
);

  window_t sorted_c;

  // One sorter per group, index 0 of each result holds the largest pixel
  for (genvar g = 0; g < WIN_SIZE; g++) begin : g_group
    sort_net #(
      .N (WIN_SIZE)
    ) sort_i (
      .ref_clk  (ref_clk),
      .rst_n    (rst_n),
      .i_vals   (i_groups[g]),
      .o_sorted (sorted_c[g])
    );
  end

  // Stage register, holds on a pipeline stall
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      o_sorted <= '0;
    end else if (i_adv) begin
      o_sorted <= sorted_c;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the median_5x5 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_median_5x5 \
  -Mdir obj_dir \
  -f median_5x5.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_median_5x5 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// ==== sort_net.sv ====
`timescale 1ns/1ps

// Odd-even transposition sorter, largest value ends up at index 0
module sort_net
  import pixel_pkg::*;
#(
  parameter int N = 5
) (
  input  logic               ref_clk,
  input  logic               rst_n,
  input  pixel_t [N-1:0]     i_vals,
  output pixel_t [N-1:0]     o_sorted
);

  always_comb begin : sort_proc
    pixel_t [N-1:0] work;
    pixel_t         hi;
    pixel_t         lo;

    work = i_vals;
    // N rounds are enough for any input order
    for (int r = 0; r < N; r++) begin
      // Even rounds pair (0,1),(2,3)..., odd rounds pair (1,2),(3,4)...
      for (int i = r % 2; i + 1 < N; i += 2) begin
        if (work[i] >= work[i+1]) begin
          hi = work[i];
          lo = work[i+1];
        end else begin
          hi = work[i+1];
          lo = work[i];
        end
        work[i]   = hi;
        work[i+1] = lo;
      end
    end
    o_sorted = work;
  end

  // Output must come out in descending order for every lane pair
  for (genvar i = 0; i < N - 1; i++) begin : g_order_chk
    a_descending: assert property (
      @(posedge ref_clk) disable iff (!rst_n)
      o_sorted[i] >= o_sorted[i+1]
    );
  end

endmodule

// ==== median_model.svh ====
`ifndef MEDIAN_MODEL_SVH
`define MEDIAN_MODEL_SVH

// n-th largest entry of a value list, n = 0 is the maximum
function automatic int nth_largest(int vals[$], int n);
  vals.rsort();
  return vals[n];
endfunction

// Rank filter result for one window, packed as {max, med, min}
function automatic logic [23:0] model_filter(window_t win);
  int row_rank [WIN_SIZE][WIN_SIZE];
  int m [WIN_SIZE][WIN_SIZE];
  int grp[$];
  int dmax;
  int dmed;
  int dmin;
  int trio[$];

  // Each row in descending order
  for (int r = 0; r < WIN_SIZE; r++) begin
    grp.delete();
    for (int c = 0; c < WIN_SIZE; c++) begin
      grp.push_back(int'(win[r][c]));
    end
    for (int k = 0; k < WIN_SIZE; k++) begin
      row_rank[r][k] = nth_largest(grp, k);
    end
  end

  // M[k][j], rank k within the row, rank j across the rows
  for (int k = 0; k < WIN_SIZE; k++) begin
    grp.delete();
    for (int r = 0; r < WIN_SIZE; r++) begin
      grp.push_back(row_rank[r][k]);
    end
    for (int j = 0; j < WIN_SIZE; j++) begin
      m[k][j] = nth_largest(grp, j);
    end
  end

  // Anti-diagonal neighborhood
  grp = {m[1][4], m[2][3], m[3][2], m[4][1]};
  dmax = nth_largest(grp, 0);
  grp = {m[0][4], m[1][3], m[2][2], m[3][1], m[4][0]};
  dmed = nth_largest(grp, 2);
  grp = {m[0][3], m[1][2], m[2][1], m[3][0]};
  dmin = nth_largest(grp, 3);

  trio = {dmax, dmed, dmin};
  return {pixel_t'(nth_largest(trio, 0)),
          pixel_t'(nth_largest(trio, 1)),
          pixel_t'(nth_largest(trio, 2))};
endfunction

`endif

// ==== tb_median_5x5.sv ====
`timescale 1ns/1ps

module tb_median_5x5
  import pixel_pkg::*;
  import pipe_pkg::*;
();

  localparam int NUM_WINDOWS  = 400;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  // 20 cycles per window leaves plenty of room for random stalls
  localparam longint TIMEOUT_NS = longint'(NUM_WINDOWS) * 20 * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;

  logic    ref_clk;
  logic    rst_n;
  logic    i_valid;
  logic    o_ready;
  window_t i_window;
  logic    o_valid;
  logic    i_ready;
  pixel_t  o_max;
  pixel_t  o_med;
  pixel_t  o_min;

  integer      seed;
  int          cycle_cnt;
  int          n_sent;
  int          n_results;
  int          cur_tag;
  logic [23:0] exp_q[$];
  int          accept_cycle_q[$];
  int          const_q[$];
  bit          directed;
  bit          stalled_in;
  bit          hold_pending;
  logic [23:0] held_out;

  `include "median_model.svh"

  median_5x5 median_5x5_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_window (i_window),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_max    (o_max),
    .o_med    (o_med),
    .o_min    (o_min)
  );

  initial begin
    ref_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ref_clk = ~ref_clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    fail_run();
  end

  task automatic fail_run();
    $display("Something failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp_val);
      fail_run();
    end
  endtask

  function automatic window_t random_window();
    window_t w;
    for (int r = 0; r < WIN_SIZE; r++) begin
      for (int c = 0; c < WIN_SIZE; c++) begin
        w[r][c] = pixel_t'($random(seed));
      end
    end
    return w;
  endfunction

  function automatic window_t const_window(pixel_t c);
    window_t w;
    for (int r = 0; r < WIN_SIZE; r++) begin
      for (int k = 0; k < WIN_SIZE; k++) begin
        w[r][k] = c;
      end
    end
    return w;
  endfunction

  // True about 70 % of the time
  function automatic bit coin70();
    return ($unsigned($random(seed)) % 100) < 70;
  endfunction

  // Scoreboard side, the result leaves on the coming edge
  task automatic take_result();
    logic [23:0] exp_res;
    int          acc_cycle;
    int          const_val;
    if (exp_q.size() == 0) begin
      $display("A result was delivered while no window was outstanding");
      fail_run();
    end else begin
      exp_res   = exp_q.pop_front();
      acc_cycle = accept_cycle_q.pop_front();
      const_val = const_q.pop_front();
      check_value("o_max", 32'(o_max), 32'(exp_res[23:16]));
      check_value("o_med", 32'(o_med), 32'(exp_res[15:8]));
      check_value("o_min", 32'(o_min), 32'(exp_res[7:0]));
      check_value("o_max >= o_med", 32'(o_max >= o_med), 32'd1);
      check_value("o_med >= o_min", 32'(o_med >= o_min), 32'd1);
      if (directed) begin
        check_value("latency", cycle_cnt - acc_cycle, PIPE_DEPTH);
      end
      // Flat window gives its own level on every output
      if (const_val >= 0) begin
        check_value("o_max", 32'(o_max), const_val);
        check_value("o_med", 32'(o_med), const_val);
        check_value("o_min", 32'(o_min), const_val);
      end
      n_results++;
    end
  endtask

  // Handshakes are judged one step after the falling edge
  task automatic evaluate();
    #1;
    if (hold_pending) begin
      check_value("o_valid", 32'(o_valid), 32'd1);
      check_value("held result", 32'({o_max, o_med, o_min}), 32'(held_out));
    end
    hold_pending = 1'b0;
    if (o_valid && !i_ready) begin
      check_value("o_ready", 32'(o_ready), 32'd0);
      hold_pending = 1'b1;
      held_out     = {o_max, o_med, o_min};
    end
    if (o_valid && i_ready) begin
      take_result();
    end
    stalled_in = i_valid && !o_ready;
    if (i_valid && o_ready) begin
      exp_q.push_back(model_filter(i_window));
      accept_cycle_q.push_back(cycle_cnt);
      const_q.push_back(cur_tag);
      n_sent++;
    end
    cycle_cnt++;
  endtask

  task automatic drive_cycle(input bit v, input window_t w, input bit r, input int tag);
    @(negedge ref_clk);
    i_valid  = v;
    i_window = w;
    i_ready  = r;
    cur_tag  = tag;
    evaluate();
  endtask

  initial begin : main_proc
    window_t win;
    pixel_t  c;
    bit      v;

    seed         = 32'h6517;
    rst_n        = 1'b0;
    i_valid      = 1'b0;
    i_ready      = 1'b0;
    i_window     = '0;
    cycle_cnt    = 0;
    n_sent       = 0;
    n_results    = 0;
    cur_tag      = -1;
    directed     = 1'b1;
    stalled_in   = 1'b0;
    hold_pending = 1'b0;
    held_out     = '0;
    win          = '0;
    v            = 1'b0;

    repeat (RESET_CYCLES) @(posedge ref_clk);
    @(negedge ref_clk);
    rst_n = 1'b1;
    #1;
    check_value("o_valid", 32'(o_valid), 32'd0);
    check_value("o_ready", 32'(o_ready), 32'd1);

    // Single window through an empty pipe
    drive_cycle(1'b1, random_window(), 1'b1, -1);
    repeat (PIPE_DEPTH + 2) drive_cycle(1'b0, '0, 1'b1, -1);
    check_value("result count", n_results, 1);

    // Back to back, results on consecutive cycles
    repeat (3) drive_cycle(1'b1, random_window(), 1'b1, -1);
    repeat (PIPE_DEPTH + 2) drive_cycle(1'b0, '0, 1'b1, -1);
    check_value("result count", n_results, 4);

    c = pixel_t'($random(seed));
    drive_cycle(1'b1, const_window(c), 1'b1, int'(c));
    repeat (PIPE_DEPTH + 2) drive_cycle(1'b0, '0, 1'b1, -1);
    check_value("result count", n_results, 5);
    directed = 1'b0;

    // Random traffic, a stalled window is held until taken
    while (n_sent < NUM_WINDOWS) begin
      if (!stalled_in) begin
        v   = coin70();
        win = random_window();
      end
      drive_cycle(v, win, coin70(), -1);
    end

    // Ready held high empties the pipe within its depth
    repeat (PIPE_DEPTH + 2) drive_cycle(1'b0, win, 1'b1, -1);

    if (n_results == n_sent) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Got %0d results for %0d accepted windows", n_results, n_sent);
      fail_run();
    end
  end

endmodule

// ==== triple_sort.sv ====
`timescale 1ns/1ps

// Final ordering of the three diagonal values
module triple_sort
  import pixel_pkg::*;
(
  input  logic   ref_clk,
  input  logic   rst_n,
  input  logic   i_adv,
  input  pixel_t i_dmax,
  input  pixel_t i_dmed,
  input  pixel_t i_dmin,
  output pixel_t o_max,
  output pixel_t o_med,
  output pixel_t o_min
);

  pixel_t [2:0] trio;
  pixel_t [2:0] trio_sorted;

  assign trio[0] = i_dmax;
  assign trio[1] = i_dmed;
  assign trio[2] = i_dmin;

  sort_net #(
    .N (3)
  ) trio_sort_i (
    .ref_clk  (ref_clk),
    .rst_n    (rst_n),
    .i_vals   (trio),
    .o_sorted (trio_sorted)
  );

  // Filter result register
  always_ff @(posedge ref_clk or negedge rst_n) begin
    if (!rst_n) begin
      o_max <= '0;
      o_med <= '0;
      o_min <= '0;
    end else if (i_adv) begin
      o_max <= trio_sorted[0];
      o_med <= trio_sorted[1];
      o_min <= trio_sorted[2];
    end
  end

endmodule
